/* build.f */
source/tcdm_pkg.sv
source/bank_pkg.sv
source/tcdm_if.sv
source/wide_router.sv
source/core_demux.sv
source/bank_arbiter.sv
source/sram_bank.sv
source/tcdm_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_top
out=$(./obj_dir/Vtb_top)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

/* tests/tb_top.sv */
`timescale 1ns/1ns

module tb_top
  import tcdm_pkg::*;
  import bank_pkg::*;
();

  // cycles any single wait may take
  localparam int TIMEOUT = 200;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              clear;
  logic                              wide_req;
  logic [AW-1:0]                     wide_add;
  logic                              wide_wen;
  logic [WIDE_W/8-1:0]               wide_be;
  logic [WIDE_W-1:0]                 wide_data;
  logic                              wide_gnt;
  logic [WIDE_W-1:0]                 wide_r_data;
  logic                              wide_r_valid;
  logic [NB_CORES-1:0]               core_req;
  logic [NB_CORES-1:0][AW-1:0]       core_add;
  logic [NB_CORES-1:0]               core_wen;
  logic [NB_CORES-1:0][WORD_W/8-1:0] core_be;
  logic [NB_CORES-1:0][WORD_W-1:0]   core_data;
  logic [NB_CORES-1:0]               core_gnt;
  logic [NB_CORES-1:0][WORD_W-1:0]   core_r_data;
  logic [NB_CORES-1:0]               core_r_valid;
  logic [31:0]                       rand_state;
  int                                test_id;
  int                                timeouts;
  int                                value_errs;
  int                                proto_errs;
  // core streams still running in the contention test
  int                                cores_left;

  // 8 ns period
  always #4 clk_i = ~clk_i;

  tcdm_top dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear),
    .wide_req_i     (wide_req),
    .wide_add_i     (wide_add),
    .wide_wen_i     (wide_wen),
    .wide_be_i      (wide_be),
    .wide_data_i    (wide_data),
    .wide_gnt_o     (wide_gnt),
    .wide_r_data_o  (wide_r_data),
    .wide_r_valid_o (wide_r_valid),
    .core_req_i     (core_req),
    .core_add_i     (core_add),
    .core_wen_i     (core_wen),
    .core_be_i      (core_be),
    .core_data_i    (core_data),
    .core_gnt_o     (core_gnt),
    .core_r_data_o  (core_r_data),
    .core_r_valid_o (core_r_valid)
  );

  tb_checker chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_id_i      (test_id),
    .wide_req_i     (wide_req),
    .wide_add_i     (wide_add),
    .wide_wen_i     (wide_wen),
    .wide_be_i      (wide_be),
    .wide_data_i    (wide_data),
    .wide_gnt_i     (wide_gnt),
    .wide_r_data_i  (wide_r_data),
    .wide_r_valid_i (wide_r_valid),
    .core_req_i     (core_req),
    .core_add_i     (core_add),
    .core_wen_i     (core_wen),
    .core_be_i      (core_be),
    .core_data_i    (core_data),
    .core_gnt_i     (core_gnt),
    .core_r_data_i  (core_r_data),
    .core_r_valid_i (core_r_valid),
    .value_errs_o   (value_errs),
    .proto_errs_o   (proto_errs)
  );

  // xorshift32 shared by all stimulus processes
  function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  function automatic logic [AW-1:0] make_addr(int row, int bank);
    bank_addr_t a;
    a.raw      = '0;
    a.fld.row  = ROW_W'(row);
    a.fld.bank = BANK_W'(bank);
    return a.raw;
  endfunction

  // preload value in which every address bit takes part
  function automatic logic [WORD_W-1:0] fill_word(logic [AW-1:0] addr);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  // one wide transfer with the request held until gnt
  // rd is the wen value
  task automatic wide_access(logic rd, logic [AW-1:0] add, logic [WIDE_W/8-1:0] be,
                             logic [WIDE_W-1:0] data);
    int waited;
    waited    = 0;
    wide_req  = 1'b1;
    wide_add  = add;
    wide_wen  = rd;
    wide_be   = be;
    wide_data = data;
    @(negedge clk_i);
    while (!wide_gnt && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!wide_gnt) begin
      timeouts++;
      $display("timeout: wide port got no grant within %0d cycles", TIMEOUT);
    end
    @(posedge clk_i);
    #1;
    wide_req = 1'b0;
  endtask

  task automatic core_access(int c, logic rd, logic [AW-1:0] add, logic [WORD_W/8-1:0] be,
                             logic [WORD_W-1:0] data);
    int waited;
    waited       = 0;
    core_req[c]  = 1'b1;
    core_add[c]  = add;
    core_wen[c]  = rd;
    core_be[c]   = be;
    core_data[c] = data;
    @(negedge clk_i);
    while (!core_gnt[c] && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!core_gnt[c]) begin
      timeouts++;
      $display("timeout: core %0d got no grant within %0d cycles", c, TIMEOUT);
    end
    @(posedge clk_i);
    #1;
    core_req[c] = 1'b0;
  endtask

  task automatic random_wide();
    logic [31:0]       r;
    logic [WIDE_W-1:0] d;
    r = next_rand();
    d = {next_rand(), next_rand(), next_rand(), next_rand()};
    wide_access(r[0], make_addr(int'(r[6:1]), int'(r[8:7])), r[31:16], d);
  endtask

  task automatic random_core(int c);
    logic [31:0] r;
    r = next_rand();
    core_access(c, r[0], make_addr(int'(r[6:1]), int'(r[8:7])), r[12:9], next_rand());
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    clear      = 1'b0;
    wide_req   = 1'b0;
    wide_add   = '0;
    wide_wen   = 1'b1;
    wide_be    = '0;
    wide_data  = '0;
    core_req   = '0;
    core_add   = '0;
    core_wen   = '1;
    core_be    = '0;
    core_data  = '0;
    rand_state = 32'hab075612;
    test_id    = 0;
    timeouts   = 0;
    cores_left = 0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // whole memory written once so no read returns an unknown word
    for (int row = 0; row < ROWS; row++) begin
      wide_access(1'b0, make_addr(row, 0), '1,
                  {fill_word(make_addr(row, 3)), fill_word(make_addr(row, 2)),
                   fill_word(make_addr(row, 1)), fill_word(make_addr(row, 0))});
    end

    // wide write followed by a core read of each word
    test_id = 1;
    wide_access(1'b0, make_addr(5, 0), '1, {next_rand(), next_rand(), next_rand(), next_rand()});
    for (int b = 0; b < NB_BANKS; b++) begin
      core_access(b % NB_CORES, 1'b1, make_addr(5, b), '1, '0);
    end

    // start bank 2 in the last row wraps onto row 0
    test_id = 2;
    wide_access(1'b0, make_addr(ROWS - 1, 2), '1,
                {next_rand(), next_rand(), next_rand(), next_rand()});
    wide_access(1'b1, make_addr(ROWS - 1, 2), '0, '0);
    core_access(0, 1'b1, make_addr(0, 0), '1, '0);
    core_access(1, 1'b1, make_addr(0, 1), '1, '0);

    test_id = 3;
    core_access(0, 1'b0, make_addr(7, 1), 4'b0101, next_rand());
    core_access(1, 1'b0, make_addr(7, 2), 4'b1000, next_rand());
    wide_access(1'b0, make_addr(7, 1), 16'h0f3c,
                {next_rand(), next_rand(), next_rand(), next_rand()});
    wide_access(1'b1, make_addr(7, 1), '0, '0);
    core_access(0, 1'b1, make_addr(7, 2), '1, '0);

    // back to back traffic on every port at once
    test_id = 4;
    fork
      for (int i = 0; i < 6; i++) wide_access(1'b1, make_addr(20 + i, 3), '0, '0);
      for (int i = 0; i < 6; i++) core_access(0, 1'(i & 1), make_addr(21, 2), '1, next_rand());
      for (int i = 0; i < 6; i++) core_access(1, 1'(i & 1), make_addr(22, 0), '1, next_rand());
    join

    // all three ports fight over bank 1
    // wide keeps asking until both cores are done, only starvation lets them in
    test_id    = 5;
    cores_left = NB_CORES;
    fork
      while (cores_left > 0) begin
        wide_access(1'b0, make_addr(10, 1), '1,
                    {next_rand(), next_rand(), next_rand(), next_rand()});
      end
      begin
        for (int i = 0; i < 12; i++) begin
          core_access(0, 1'b1, make_addr(10, 1), '1, '0);
        end
        cores_left--;
      end
      begin
        for (int i = 0; i < 12; i++) begin
          core_access(1, 1'b0, make_addr(10, 1), '1, next_rand());
        end
        cores_left--;
      end
    join

    // 300 transfers in total
    test_id = 6;
    fork
      repeat (60) random_wide();
      repeat (120) random_core(0);
      repeat (120) random_core(1);
    join

    // last responses arrive one cycle after their grant
    repeat (3) @(negedge clk_i);
    $display("errors: %0d value, %0d protocol, %0d timeout", value_errs, proto_errs, timeouts);
    if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ns

module tb_checker
  import tcdm_pkg::*;
  import bank_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  int                                test_id_i,
  input  logic                              wide_req_i,
  input  logic [AW-1:0]                     wide_add_i,
  input  logic                              wide_wen_i,
  input  logic [WIDE_W/8-1:0]               wide_be_i,
  input  logic [WIDE_W-1:0]                 wide_data_i,
  input  logic                              wide_gnt_i,
  input  logic [WIDE_W-1:0]                 wide_r_data_i,
  input  logic                              wide_r_valid_i,
  input  logic [NB_CORES-1:0]               core_req_i,
  input  logic [NB_CORES-1:0][AW-1:0]       core_add_i,
  input  logic [NB_CORES-1:0]               core_wen_i,
  input  logic [NB_CORES-1:0][WORD_W/8-1:0] core_be_i,
  input  logic [NB_CORES-1:0][WORD_W-1:0]   core_data_i,
  input  logic [NB_CORES-1:0]               core_gnt_i,
  input  logic [NB_CORES-1:0][WORD_W-1:0]   core_r_data_i,
  input  logic [NB_CORES-1:0]               core_r_valid_i,
  output int                                value_errs_o,
  output int                                proto_errs_o
);

  // model memory, index is row * NB_BANKS + bank
  logic [WORD_W-1:0]   model [NB_BANKS*ROWS];
  // expected responses, top bit marks a read
  logic [WIDE_W:0]     wide_q [$];
  logic [WORD_W:0]     core_q [NB_CORES][$];
  logic                wide_gnt_q;
  logic [NB_CORES-1:0] core_gnt_q;
  int                  value_errs;
  int                  proto_errs;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;

  initial begin
    value_errs = 0;
    proto_errs = 0;
    for (int i = 0; i < NB_BANKS * ROWS; i++) model[i] = '0;
  end

  function automatic string test_label(int id);
    case (id)
      0: return "preload";
      1: return "wide_write_core_read";
      2: return "wide_row_wrap";
      3: return "byte_enables";
      4: return "response_timing";
      5: return "contention";
      6: return "random_mix";
      default: return "unknown";
    endcase
  endfunction

  // channel ch sits on bank start+ch, one row further when that passes the last bank
  function automatic int word_index(logic [AW-1:0] addr, int ch);
    bank_addr_t a;
    int         bank;
    int         row;
    a.raw = addr;
    bank  = int'(a.fld.bank) + ch;
    row   = int'(a.fld.row);
    if (bank >= int'(NB_BANKS)) row = (row + 1) % int'(ROWS);
    return row * int'(NB_BANKS) + bank % int'(NB_BANKS);
  endfunction

  // expected wide read data in channel order
  function automatic logic [WIDE_W-1:0] ref_wide_read(logic [AW-1:0] addr);
    logic [WIDE_W-1:0] res;
    for (int i = 0; i < NB_WIDE_CH; i++) res[i*WORD_W +: WORD_W] = model[word_index(addr, i)];
    return res;
  endfunction

  task automatic write_word(int idx, logic [WORD_W/8-1:0] be, logic [WORD_W-1:0] data);
    for (int b = 0; b < WORD_W / 8; b++) begin
      if (be[b]) model[idx][b*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  task automatic report_response(string port, logic valid, logic granted, logic [WIDE_W:0] ent,
                                 logic [WIDE_W-1:0] act);
    if (valid && !granted) begin
      proto_errs++;
      $display("%s: r_valid without a grant in the cycle before, test %s", port,
               test_label(test_id_i));
    end else if (!valid && granted) begin
      proto_errs++;
      $display("%s: no r_valid one cycle after its grant, test %s", port, test_label(test_id_i));
    end else if (valid && ent[WIDE_W] && act !== ent[WIDE_W-1:0]) begin
      value_errs++;
      $display("Fail %s: %s expected %h actual %h", test_label(test_id_i), port,
               ent[WIDE_W-1:0], act);
    end
  endtask

  always @(negedge clk_i) begin
    logic [WIDE_W:0] ent;
    logic [WORD_W:0] ce;
    if (!rst_ni) begin
      wide_gnt_q = 1'b0;
      core_gnt_q = '0;
      wide_q.delete();
      for (int c = 0; c < NB_CORES; c++) core_q[c].delete();
    end else begin
      // responses belong to last cycle's grants
      ent = '0;
      if (wide_gnt_q) ent = wide_q.pop_front();
      report_response("wide port", wide_r_valid_i, wide_gnt_q, ent, wide_r_data_i);
      for (int c = 0; c < NB_CORES; c++) begin
        ent = '0;
        if (core_gnt_q[c]) begin
          ce                = core_q[c].pop_front();
          ent[WIDE_W]       = ce[WORD_W];
          ent[WORD_W-1:0]   = ce[WORD_W-1:0];
        end
        report_response($sformatf("core %0d", c), core_r_valid_i[c], core_gnt_q[c], ent,
                        WIDE_W'(core_r_data_i[c]));
      end

      // new grants update the model, wide first then cores by index
      if (wide_req_i && wide_gnt_i) begin
        if (wide_wen_i) begin
          wide_q.push_back({1'b1, ref_wide_read(wide_add_i)});
        end else begin
          for (int ch = 0; ch < NB_WIDE_CH; ch++) begin
            write_word(word_index(wide_add_i, ch), wide_be_i[ch*(WORD_W/8) +: WORD_W/8],
                       wide_data_i[ch*WORD_W +: WORD_W]);
          end
          wide_q.push_back('0);
        end
      end
      for (int c = 0; c < NB_CORES; c++) begin
        if (core_req_i[c] && core_gnt_i[c]) begin
          if (core_wen_i[c]) begin
            core_q[c].push_back({1'b1, model[word_index(core_add_i[c], 0)]});
          end else begin
            write_word(word_index(core_add_i[c], 0), core_be_i[c], core_data_i[c]);
            core_q[c].push_back('0);
          end
        end
      end
      wide_gnt_q = wide_req_i & wide_gnt_i;
      core_gnt_q = core_req_i & core_gnt_i;
    end
  end

endmodule

/* source/tcdm_top.sv */
`timescale 1ns/1ns

module tcdm_top
  import tcdm_pkg::*;
  import bank_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,

  input  logic                               wide_req_i,
  input  logic [AW-1:0]                      wide_add_i,
  input  logic                               wide_wen_i,
  input  logic [WIDE_W/8-1:0]                wide_be_i,
  input  logic [WIDE_W-1:0]                  wide_data_i,
  output logic                               wide_gnt_o,
  output logic [WIDE_W-1:0]                  wide_r_data_o,
  output logic                               wide_r_valid_o,

  input  logic [NB_CORES-1:0]                core_req_i,
  input  logic [NB_CORES-1:0][AW-1:0]        core_add_i,
  input  logic [NB_CORES-1:0]                core_wen_i,
  input  logic [NB_CORES-1:0][WORD_W/8-1:0]  core_be_i,
  input  logic [NB_CORES-1:0][WORD_W-1:0]    core_data_i,
  output logic [NB_CORES-1:0]                core_gnt_o,
  output logic [NB_CORES-1:0][WORD_W-1:0]    core_r_data_o,
  output logic [NB_CORES-1:0]                core_r_valid_o
);

  logic [NB_BANKS-1:0] starve;

  tcdm_if #(.DW(WIDE_W)) wide_if ();
  // router word channels, indexed by bank
  tcdm_if router_ch [NB_BANKS] ();

  assign wide_if.req     = wide_req_i;
  assign wide_if.add     = wide_add_i;
  assign wide_if.wen     = wide_wen_i;
  assign wide_if.be      = wide_be_i;
  assign wide_if.data    = wide_data_i;
  assign wide_gnt_o      = wide_if.gnt;
  assign wide_r_data_o   = wide_if.r_data;
  assign wide_r_valid_o  = wide_if.r_valid;

  wide_router u_router (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .wide     (wide_if),
    .bank_ch  (router_ch),
    .starve_i (starve)
  );

  for (genvar c = 0; c < NB_CORES; c++) begin : g_core
    tcdm_if core_if ();
    // demux side of the core to bank links
    tcdm_if dmx_bank [NB_BANKS] ();

    assign core_if.req       = core_req_i[c];
    assign core_if.add       = core_add_i[c];
    assign core_if.wen       = core_wen_i[c];
    assign core_if.be        = core_be_i[c];
    assign core_if.data      = core_data_i[c];
    assign core_gnt_o[c]     = core_if.gnt;
    assign core_r_data_o[c]  = core_if.r_data;
    assign core_r_valid_o[c] = core_if.r_valid;

    core_demux u_demux (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .clear_i (clear_i),
      .core    (core_if),
      .to_bank (dmx_bank)
    );
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    // arbiter side of the same links, indexed by core
    tcdm_if arb_core [NB_CORES] ();
    tcdm_if mem_if ();

    bank_arbiter u_arb (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .clear_i  (clear_i),
      .wide_ch  (router_ch[b]),
      .cores    (arb_core),
      .mem      (mem_if),
      .starve_o (starve[b])
    );

    sram_bank u_sram (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .port   (mem_if)
    );
  end

  // transpose core x bank links, demux arrays are per core, arbiter arrays per bank
  for (genvar c = 0; c < NB_CORES; c++) begin : g_link_core
    for (genvar b = 0; b < NB_BANKS; b++) begin : g_link_bank
      assign g_bank[b].arb_core[c].req  = g_core[c].dmx_bank[b].req;
      assign g_bank[b].arb_core[c].add  = g_core[c].dmx_bank[b].add;
      assign g_bank[b].arb_core[c].wen  = g_core[c].dmx_bank[b].wen;
      assign g_bank[b].arb_core[c].be   = g_core[c].dmx_bank[b].be;
      assign g_bank[b].arb_core[c].data = g_core[c].dmx_bank[b].data;

      assign g_core[c].dmx_bank[b].gnt     = g_bank[b].arb_core[c].gnt;
      assign g_core[c].dmx_bank[b].r_data  = g_bank[b].arb_core[c].r_data;
      assign g_core[c].dmx_bank[b].r_valid = g_bank[b].arb_core[c].r_valid;
    end
  end

endmodule

/* source/sram_bank.sv */
`timescale 1ns/1ns

module sram_bank
  import tcdm_pkg::*;
  import bank_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  tcdm_if.target port
);

  logic [WORD_W-1:0] mem_q [ROWS];
  logic [WORD_W-1:0] rdata_q;
  logic              rvalid_q;
  bank_addr_t        addr;

  // bank select already done upstream, only the row matters here
  assign addr = port.add;

  // single port array, never busy
  assign port.gnt     = 1'b1;
  assign port.r_data  = rdata_q;
  assign port.r_valid = rvalid_q;

  always_ff @(posedge clk_i) begin
    if (port.req) begin
      if (port.wen) begin
        rdata_q <= mem_q[addr.fld.row];
      end else begin
        // byte lanes written only where be is set
        for (int b = 0; b < WORD_W / 8; b++) begin
          if (port.be[b]) begin
            mem_q[addr.fld.row][b*8 +: 8] <= port.data[b*8 +: 8];
          end
        end
      end
    end
  end

  // r_valid for reads and writes alike, one cycle after the access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= port.req;
    end
  end

endmodule

/* source/bank_arbiter.sv */
`timescale 1ns/1ns

module bank_arbiter
  import tcdm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  tcdm_if.target    wide_ch,
  tcdm_if.target    cores [NB_CORES],
  tcdm_if.initiator mem,
  output logic      starve_o
);

  logic [NB_CORES-1:0] core_req;
  logic [NB_CORES-1:0] core_win;
  logic [NB_CORES-1:0] core_gnt;
  logic [NB_CORES-1:0] core_own_q;
  logic [NB_CORES-1:0] core_wen;
  logic [AW-1:0]       core_add [NB_CORES];
  logic [WORD_W/8-1:0] core_be [NB_CORES];
  logic [WORD_W-1:0]   core_data [NB_CORES];
  logic [CORE_W-1:0]   rr_q;
  logic [CORE_W-1:0]   win_idx;
  logic                wide_gnt;
  logic                wide_own_q;
  logic [STARVE_W-1:0] starve_cnt_q;

  for (genvar c = 0; c < NB_CORES; c++) begin : g_core
    assign core_req[c]  = cores[c].req;
    assign core_add[c]  = cores[c].add;
    assign core_wen[c]  = cores[c].wen;
    assign core_be[c]   = cores[c].be;
    assign core_data[c] = cores[c].data;

    assign cores[c].gnt     = core_gnt[c];
    // response only to the core that owned the bank last cycle
    assign cores[c].r_valid = mem.r_valid & core_own_q[c];
    assign cores[c].r_data  = mem.r_data;
  end

  // round robin, first requester at or after the pointer
  always_comb begin
    core_win = '0;
    win_idx  = rr_q;
    // walk from the far end down so the closest candidate is kept
    for (int k = NB_CORES - 1; k >= 0; k--) begin
      int unsigned cand;
      cand = (int'(rr_q) + k) % NB_CORES;
      if (core_req[cand]) begin
        win_idx = CORE_W'(cand);
      end
    end
    core_win[win_idx] = |core_req;
  end

  // wide channel always wins when present
  assign wide_gnt = wide_ch.req & mem.gnt;
  assign core_gnt = (wide_ch.req || !mem.gnt) ? '0 : core_win;

  assign wide_ch.gnt     = wide_gnt;
  assign wide_ch.r_valid = mem.r_valid & wide_own_q;
  assign wide_ch.r_data  = mem.r_data;

  // forward the winner to the bank
  assign mem.req  = wide_ch.req | (|core_req);
  assign mem.add  = wide_ch.req ? wide_ch.add  : core_add[win_idx];
  assign mem.wen  = wide_ch.req ? wide_ch.wen  : core_wen[win_idx];
  assign mem.be   = wide_ch.req ? wide_ch.be   : core_be[win_idx];
  assign mem.data = wide_ch.req ? wide_ch.data : core_data[win_idx];

  // tells the router to skip one wide access
  assign starve_o = (starve_cnt_q == STARVE_W'(STARVE_LIMIT));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wide_own_q   <= 1'b0;
      core_own_q   <= '0;
      rr_q         <= '0;
      starve_cnt_q <= '0;
    end else if (clear_i) begin
      wide_own_q   <= 1'b0;
      core_own_q   <= '0;
      rr_q         <= '0;
      starve_cnt_q <= '0;
    end else begin
      wide_own_q <= wide_gnt;
      core_own_q <= core_gnt;
      if (|core_gnt) begin
        // next search starts after the served core
        rr_q         <= CORE_W'((int'(win_idx) + 1) % NB_CORES);
        starve_cnt_q <= '0;
      end else if (|core_req && !starve_o) begin
        // a core waited and got nothing, saturates at the limit
        starve_cnt_q <= starve_cnt_q + STARVE_W'(1);
      end
    end
  end

endmodule

/* source/core_demux.sv */
`timescale 1ns/1ns

module core_demux
  import tcdm_pkg::*;
  import bank_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  tcdm_if.target    core,
  tcdm_if.initiator to_bank [NB_BANKS]
);

  bank_addr_t          core_addr;
  logic [BANK_W-1:0]   sel;
  logic [BANK_W-1:0]   sel_q;
  logic [NB_BANKS-1:0] bank_gnt;
  logic [NB_BANKS-1:0] bank_rvalid;
  logic [WORD_W-1:0]   bank_rdata [NB_BANKS];

  assign core_addr = core.add;
  // target bank from the interleave bits
  assign sel       = core_addr.fld.bank;

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    // only the addressed bank sees req, fields are broadcast
    assign to_bank[b].req  = core.req & (sel == BANK_W'(b));
    assign to_bank[b].add  = core.add;
    assign to_bank[b].wen  = core.wen;
    assign to_bank[b].be   = core.be;
    assign to_bank[b].data = core.data;

    assign bank_gnt[b]    = to_bank[b].gnt;
    assign bank_rvalid[b] = to_bank[b].r_valid;
    assign bank_rdata[b]  = to_bank[b].r_data;
  end

  assign core.gnt = bank_gnt[sel];

  // response comes from the bank granted in the previous cycle
  // that bank's arbiter only pulses r_valid toward us if it was our grant
  assign core.r_valid = bank_rvalid[sel_q];
  assign core.r_data  = bank_rdata[sel_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else if (clear_i) begin
      sel_q <= '0;
    end else if (core.req && core.gnt) begin
      sel_q <= sel;
    end
  end

endmodule

/* source/wide_router.sv */
`timescale 1ns/1ns

module wide_router
  import tcdm_pkg::*;
  import bank_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  tcdm_if.target              wide,
  tcdm_if.initiator           bank_ch [NB_BANKS],
  input  logic [NB_BANKS-1:0] starve_i
);

  bank_addr_t            wide_addr;
  logic [BANK_W-1:0]     start_bank;
  logic                  go;
  logic                  gnt_q;
  logic [BANK_W-1:0]     start_q;
  logic [NB_BANKS-1:0]   bank_gnt;
  logic [NB_BANKS-1:0]   bank_rvalid;
  logic [WORD_W-1:0]     bank_rdata [NB_BANKS];
  logic [WORD_W-1:0]     ch_data [NB_WIDE_CH];
  logic [WORD_W/8-1:0]   ch_be [NB_WIDE_CH];
  logic [ROW_W-1:0]      ch_row [NB_WIDE_CH];

  assign wide_addr  = wide.add;
  // word 0 of the access lands on this bank
  assign start_bank = wide_addr.fld.bank;

  // any starving bank holds off the whole access, keeps it atomic
  assign go = wide.req & ~(|starve_i);

  for (genvar i = 0; i < NB_WIDE_CH; i++) begin : g_chan
    assign ch_data[i] = wide.data[i*WORD_W +: WORD_W];
    assign ch_be[i]   = wide.be[i*(WORD_W/8) +: WORD_W/8];

    // channels rotated past the last bank continue on the next row
    // row wraps modulo ROWS
    assign ch_row[i] = (int'(start_bank) + i >= NB_BANKS) ?
                       wide_addr.fld.row + ROW_W'(1) : wide_addr.fld.row;

    // read data back in channel order, using the start bank of the granted access
    assign wide.r_data[i*WORD_W +: WORD_W] = bank_rdata[BANK_W'(start_q + BANK_W'(i))];
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    logic [BANK_W-1:0] ch_idx;
    bank_addr_t        bank_addr;

    // channel that feeds this bank, subtraction wraps modulo NB_BANKS
    assign ch_idx = BANK_W'(b) - start_bank;

    always_comb begin
      bank_addr            = wide_addr;
      bank_addr.fld.row    = ch_row[ch_idx];
      bank_addr.fld.bank   = BANK_W'(b);
      bank_addr.fld.offset = '0;
    end

    assign bank_ch[b].req  = go;
    assign bank_ch[b].add  = bank_addr.raw;
    assign bank_ch[b].wen  = wide.wen;
    assign bank_ch[b].be   = ch_be[ch_idx];
    assign bank_ch[b].data = ch_data[ch_idx];

    assign bank_gnt[b]    = bank_ch[b].gnt;
    assign bank_rvalid[b] = bank_ch[b].r_valid;
    assign bank_rdata[b]  = bank_ch[b].r_data;
  end

  // all four banks must take their word in the same cycle
  assign wide.gnt = go & (&bank_gnt);

  // responses only for an access this router had granted
  assign wide.r_valid = gnt_q & (&bank_rvalid);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= wide.gnt;
    end
  end

  // rotation of the response follows the granted access
  always_ff @(posedge clk_i) begin
    if (wide.gnt) begin
      start_q <= start_bank;
    end
  end

endmodule

/* source/tcdm_if.sv */
`timescale 1ns/1ns

interface tcdm_if
  import tcdm_pkg::*;
#(
  parameter int unsigned DW = WORD_W
) ();

  // request side, held until gnt
  logic            req;
  logic [AW-1:0]   add;
  // 1 for read, 0 for write
  logic            wen;
  logic [DW/8-1:0] be;
  logic [DW-1:0]   data;
  logic            gnt;

  // response side, exactly one cycle after gnt
  logic [DW-1:0]   r_data;
  logic            r_valid;

  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  modport target (
    input  req, add, wen, be, data,
    output gnt, r_data, r_valid
  );

endinterface

/* source/bank_pkg.sv */
package bank_pkg;

  import tcdm_pkg::*;

  // word interleaved banks, one per wide channel
  localparam int unsigned NB_BANKS = 4;
  localparam int unsigned BANK_W = $clog2(NB_BANKS);

  // words per bank, 1 KiB over all banks
  localparam int unsigned ROWS = 64;
  localparam int unsigned ROW_W = $clog2(ROWS);

  // byte within a word and the address bits above the memory
  localparam int unsigned OFFSET_W = $clog2(WORD_W / 8);
  localparam int unsigned UNUSED_W = AW - ROW_W - BANK_W - OFFSET_W;

  typedef struct packed {
    logic [UNUSED_W-1:0] unused;
    logic [ROW_W-1:0]    row;
    logic [BANK_W-1:0]   bank;
    logic [OFFSET_W-1:0] offset;
  } bank_field_t;

  // same address word, either raw or split into bank fields
  typedef union packed {
    logic [AW-1:0] raw;
    bank_field_t   fld;
  } bank_addr_t;

endpackage

/* source/tcdm_pkg.sv */
package tcdm_pkg;

  // byte address width seen by every port
  localparam int unsigned AW = 32;

  // one bank word, also the width of a core port
  localparam int unsigned WORD_W = 32;

  // accelerator port, one bank word per channel
  localparam int unsigned WIDE_W = 128;
  localparam int unsigned NB_WIDE_CH = WIDE_W / WORD_W;

  // narrow initiators sharing the banks with the wide port
  localparam int unsigned NB_CORES = 2;
  localparam int unsigned CORE_W = $clog2(NB_CORES);

  // refused cycles a core tolerates at one bank before the wide port backs off
  localparam int unsigned STARVE_LIMIT = 4;
  localparam int unsigned STARVE_W = $clog2(STARVE_LIMIT + 1);

endpackage
